/* voice_ctrl_pkg.sv */
`default_nettype none

package voice_ctrl_pkg;

    localparam int unsigned NUM_BUTTONS = 4;        // talk, mute, effect, gate

    // bit positions in the button word
    localparam int unsigned BTN_TALK   = 0;
    localparam int unsigned BTN_MUTE   = 1;
    localparam int unsigned BTN_EFFECT = 2;
    localparam int unsigned BTN_GATE   = 3;

    localparam int unsigned DEBOUNCE_CYCLES = 16;   // short so sims stay quick
    localparam int unsigned DB_CNT_W = $clog2(DEBOUNCE_CYCLES);
    localparam logic [DB_CNT_W-1:0] DB_CNT_LAST = DB_CNT_W'(DEBOUNCE_CYCLES - 1);

    localparam int unsigned VOL_W = 4;              // volume register width
    localparam logic [VOL_W-1:0] VOL_MAX = 4'd15;   // saturation ceiling

    // live control state seen by the audio pipeline
    typedef struct packed {
        logic talk;                                 // follows held talk button
        logic mute;                                 // toggled by mute button
        logic effect;                               // hard clip enable
        logic noise_gate;                           // small sample squelch
    } voice_mode_t;

endpackage

`default_nettype wire

/* voice_audio_pkg.sv */
`default_nettype none

package voice_audio_pkg;

    localparam int unsigned SAMPLE_W = 16;          // pcm sample width

    typedef logic signed [SAMPLE_W-1:0] sample_t;   // two's complement pcm

    // magnitudes under this are treated as noise when gating
    localparam sample_t GATE_THRESHOLD = 16'sd256;
    // clip level for the distortion effect, applied after gain
    localparam sample_t EFFECT_CLIP = 16'sd4096;

    localparam int unsigned VOL_SHIFT = 4;          // gain is volume / 16

    // one sample on the stream, no handshake
    typedef struct packed {
        logic    valid;                             // beat strobe
        sample_t sample;                            // payload
    } audio_beat_t;

endpackage

`default_nettype wire

/* input_sync.sv */
`default_nettype none

module input_sync (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] pbs,       // raw buttons
    input  wire logic [1:0]                             vol,       // raw knob phases
    output logic      [voice_ctrl_pkg::NUM_BUTTONS-1:0] btn_db,    // debounced buttons
    output logic      [1:0]                             knob_sync  // synced knob
);

    logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] pbs_meta;   // first sync stage
    logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] pbs_sync;   // second sync stage
    logic [1:0]                             vol_meta;   // first knob stage

    // one settle counter per button
    logic [voice_ctrl_pkg::NUM_BUTTONS-1:0][voice_ctrl_pkg::DB_CNT_W-1:0] db_cnt;

    // two flop synchronizers on all six inputs
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pbs_meta  <= '0;
            pbs_sync  <= '0;
            vol_meta  <= '0;
            knob_sync <= '0;
        end else begin
            pbs_meta  <= pbs;
            pbs_sync  <= pbs_meta;
            vol_meta  <= vol;
            knob_sync <= vol_meta;                  // decoded by volume_encoder
        end
    end

    // debounce, each button on its own
    // a bit flips only after the synced level has disagreed with it
    // on DEBOUNCE_CYCLES back to back edges
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            db_cnt <= '0;
            btn_db <= '0;
        end else begin
            for (int i = 0; i < voice_ctrl_pkg::NUM_BUTTONS; i++) begin
                if (pbs_sync[i] == btn_db[i]) begin
                    db_cnt[i] <= '0;                // agree, restart window
                end else if (db_cnt[i] == voice_ctrl_pkg::DB_CNT_LAST) begin
                    db_cnt[i] <= '0;
                    btn_db[i] <= pbs_sync[i];       // stable long enough
                end else begin
                    db_cnt[i] <= db_cnt[i] + 1'b1;  // still settling
                end
            end
        end
    end

endmodule

`default_nettype wire

/* mode_toggle.sv */
`default_nettype none

module mode_toggle (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] btn_db,  // debounced buttons
    output voice_ctrl_pkg::voice_mode_t                 mode     // current control state
);

    logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] btn_prev;   // last cycle's buttons
    logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] btn_rise;   // press events

    assign btn_rise = btn_db & ~btn_prev;               // per bit, no priority

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            btn_prev <= '0;
        end else begin
            btn_prev <= btn_db;
        end
    end

    // toggles are independent so two presses in one cycle both land
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mode <= '0;
        end else begin
            mode.talk <= btn_db[voice_ctrl_pkg::BTN_TALK];  // level, not latched
            if (btn_rise[voice_ctrl_pkg::BTN_MUTE]) begin
                mode.mute <= ~mode.mute;
            end
            if (btn_rise[voice_ctrl_pkg::BTN_EFFECT]) begin
                mode.effect <= ~mode.effect;
            end
            if (btn_rise[voice_ctrl_pkg::BTN_GATE]) begin
                mode.noise_gate <= ~mode.noise_gate;
            end
        end
    end

endmodule

`default_nettype wire

/* volume_encoder.sv */
`default_nettype none

module volume_encoder (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire logic [1:0]                       knob_sync,  // synced quadrature pair
    output logic      [voice_ctrl_pkg::VOL_W-1:0] volume      // saturating level
);

    logic [1:0] knob_prev;      // phase seen last cycle
    logic       step_cw;        // one detent clockwise
    logic       step_acw;       // one detent anticlockwise

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            knob_prev <= '0;
        end else begin
            knob_prev <= knob_sync;
        end
    end

    // gray order 00 01 11 10 is clockwise, reverse is anticlockwise
    // a jump of both bits is ambiguous and ignored
    always_comb begin
        step_cw  = 1'b0;
        step_acw = 1'b0;
        case ({knob_prev, knob_sync})
            4'b00_01, 4'b01_11, 4'b11_10, 4'b10_00: step_cw  = 1'b1;
            4'b00_10, 4'b10_11, 4'b11_01, 4'b01_00: step_acw = 1'b1;
            default: ;                                  // idle or illegal jump
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            volume <= '0;
        end else if (step_cw && volume != voice_ctrl_pkg::VOL_MAX) begin
            volume <= volume + 1'b1;                    // stops at max
        end else if (step_acw && volume != '0) begin
            volume <= volume - 1'b1;                    // stops at zero
        end
    end

endmodule

`default_nettype wire

/* audio_path.sv */
`default_nettype none

module audio_path (
    input  wire logic                             clk,
    input  wire logic                             rst,
    input  wire voice_audio_pkg::audio_beat_t     in_beat,   // incoming sample strobe
    input  wire voice_ctrl_pkg::voice_mode_t      mode,      // live controls
    input  wire logic [voice_ctrl_pkg::VOL_W-1:0] volume,    // live gain
    output voice_audio_pkg::audio_beat_t          out_beat   // result, two cycles later
);

    // stage 1, sample plus the controls it was captured with
    logic                             s1_valid;
    voice_audio_pkg::sample_t         s1_sample;
    voice_ctrl_pkg::voice_mode_t      s1_mode;
    logic [voice_ctrl_pkg::VOL_W-1:0] s1_volume;

    // stage 1 math
    voice_audio_pkg::sample_t gated;                        // after noise gate
    logic signed [voice_audio_pkg::SAMPLE_W+voice_ctrl_pkg::VOL_W:0] product;
    logic signed [voice_audio_pkg::SAMPLE_W+voice_ctrl_pkg::VOL_W:0] product_sh;
    voice_audio_pkg::sample_t scaled;                       // gain applied
    voice_audio_pkg::sample_t clipped;                      // effect applied
    voice_audio_pkg::sample_t final_sample;                 // after silencing

    // stage 2
    logic                     s2_valid;
    voice_audio_pkg::sample_t s2_sample;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= in_beat.valid;
            s2_valid <= s1_valid;
        end
    end

    // controls ride with the sample so later knob or button
    // changes leave samples already in flight alone
    always_ff @(posedge clk) begin
        if (in_beat.valid) begin
            s1_sample <= in_beat.sample;
            s1_mode   <= mode;
            s1_volume <= volume;
        end
    end

    always_comb begin
        // gate on |x| < threshold, written as a range so -32768 is safe
        if (s1_mode.noise_gate && s1_sample < voice_audio_pkg::GATE_THRESHOLD
                && s1_sample > -voice_audio_pkg::GATE_THRESHOLD) begin
            gated = '0;
        end else begin
            gated = s1_sample;
        end

        product    = gated * $signed({1'b0, s1_volume});   // volume is unsigned
        product_sh = product >>> voice_audio_pkg::VOL_SHIFT;  // floor divide by 16
        scaled     = product_sh[voice_audio_pkg::SAMPLE_W-1:0];  // 15/16 gain fits

        if (s1_mode.effect && scaled > voice_audio_pkg::EFFECT_CLIP) begin
            clipped = voice_audio_pkg::EFFECT_CLIP;         // hard clip top
        end else if (s1_mode.effect && scaled < -voice_audio_pkg::EFFECT_CLIP) begin
            clipped = -voice_audio_pkg::EFFECT_CLIP;        // hard clip bottom
        end else begin
            clipped = scaled;
        end

        // muted or talk released, stream keeps its timing but goes quiet
        final_sample = (s1_mode.mute || !s1_mode.talk) ? '0 : clipped;
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            s2_sample <= final_sample;
        end
    end

    assign out_beat.valid  = s2_valid;
    assign out_beat.sample = s2_sample;

endmodule

`default_nettype wire

/* voice_ctrl_top.sv */
`default_nettype none

module voice_ctrl_top (
    input  wire logic                                   clk,
    input  wire logic                                   rst,
    input  wire logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] pbs,       // talk mute effect gate
    input  wire logic [1:0]                             vol,       // quadrature knob
    input  wire voice_audio_pkg::audio_beat_t           in_beat,   // mic side samples
    output voice_ctrl_pkg::voice_mode_t                 mode,      // control state out
    output logic      [voice_ctrl_pkg::VOL_W-1:0]       volume,    // current level
    output voice_audio_pkg::audio_beat_t                out_beat   // speaker side samples
);

    logic [voice_ctrl_pkg::NUM_BUTTONS-1:0] btn_db;     // clean button levels
    logic [1:0]                             knob_sync;  // synced knob phases

    input_sync u_input_sync (
        .clk       (clk),
        .rst       (rst),
        .pbs       (pbs),
        .vol       (vol),
        .btn_db    (btn_db),
        .knob_sync (knob_sync)
    );

    mode_toggle u_mode_toggle (
        .clk    (clk),
        .rst    (rst),
        .btn_db (btn_db),
        .mode   (mode)
    );

    volume_encoder u_volume_encoder (
        .clk       (clk),
        .rst       (rst),
        .knob_sync (knob_sync),
        .volume    (volume)
    );

    // mode and volume fan out to both the pipeline and the ports
    audio_path u_audio_path (
        .clk      (clk),
        .rst      (rst),
        .in_beat  (in_beat),
        .mode     (mode),
        .volume   (volume),
        .out_beat (out_beat)
    );

endmodule

`default_nettype wire

/* voice_checker.sv */
`default_nettype none

module voice_checker (
    input  wire logic                                 clk,
    input  wire logic                                 rst,
    input  wire voice_ctrl_pkg::voice_mode_t          mode,        // dut control state
    input  wire logic [voice_ctrl_pkg::VOL_W-1:0]     volume,      // dut volume
    input  wire voice_audio_pkg::audio_beat_t         out_beat,    // dut sample stream
    input  wire logic                                 ctrl_chk,    // compare mode and volume
    input  wire voice_ctrl_pkg::voice_mode_t          exp_mode,
    input  wire logic [voice_ctrl_pkg::VOL_W-1:0]     exp_volume,
    input  wire voice_audio_pkg::audio_beat_t         exp_beat,    // valid is the strobe
    output int                                        err_count,
    output int                                        chk_count
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        err_count = 0;
        chk_count = 0;
    end

    // sampled on the rising edge, so values are the ones held over the last cycle
    always @(posedge clk) begin
        if (!rst) begin
            if (ctrl_chk) begin
                chk_count = chk_count + 2;
                if (mode !== exp_mode) begin
                    err_count++;
                    $display("[FAIL] t=%0t mode expected %b actual %b",
                             $time, exp_mode, mode);         // talk mute effect gate
                end
                if (volume !== exp_volume) begin
                    err_count++;
                    $display("[FAIL] t=%0t volume expected %0d actual %0d",
                             $time, exp_volume, volume);
                end
            end

            chk_count++;                                     // valid checked every cycle
            if (out_beat.valid !== exp_beat.valid) begin
                err_count++;
                $display("[FAIL] t=%0t out_beat.valid expected %b actual %b",
                         $time, exp_beat.valid, out_beat.valid);
            end else if (exp_beat.valid) begin
                chk_count++;
                if (out_beat.sample !== exp_beat.sample) begin
                    err_count++;
                    $display("[FAIL] t=%0t out_beat.sample expected %0d actual %0d",
                             $time, exp_beat.sample, out_beat.sample);
                end
            end
        end
    end

endmodule

`default_nettype wire

/* tb_voice_ctrl.sv */
`default_nettype none

module tb_voice_ctrl;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_ROWS    = 16;
    localparam int NUM_RANDOM  = 48;                         // back to back samples at the end
    localparam int FULL_HOLD   = voice_ctrl_pkg::DEBOUNCE_CYCLES + 6;
    localparam int SHORT_HOLD  = 8;                          // well under the debounce window
    localparam int WATCHDOG_NS = NUM_ROWS * 120 * 8 + 2000;

    // one table row, stimulus then expected results
    typedef struct packed {
        logic [3:0]                  press;                  // buttons pressed then released
        logic [7:0]                  hold;                   // cycles held, same for release
        logic                        talk;                   // talk button level for the row
        logic signed [7:0]           steps;                  // knob steps, negative is acw
        logic                        jump;                   // flip both knob bits once
        voice_audio_pkg::sample_t    sample;
        voice_ctrl_pkg::voice_mode_t exp_mode;
        logic [3:0]                  exp_vol;
        voice_audio_pkg::sample_t    exp_sample;
    } row_t;

    logic                         clk;
    logic                         rst;
    logic [3:0]                   pbs;
    logic [1:0]                   vol;
    voice_audio_pkg::audio_beat_t in_beat;
    voice_ctrl_pkg::voice_mode_t  mode;
    logic [3:0]                   volume;
    voice_audio_pkg::audio_beat_t out_beat;

    voice_audio_pkg::audio_beat_t exp_now;                   // expectation for the beat sent now
    voice_audio_pkg::audio_beat_t exp_d1;
    voice_audio_pkg::audio_beat_t exp_d2;                    // lines up with out_beat
    voice_ctrl_pkg::voice_mode_t  exp_mode;
    logic [3:0]                   exp_volume;
    logic                         ctrl_chk;
    int                           err_count;
    int                           chk_count;

    row_t                         rows [NUM_ROWS];
    int                           n_rows;
    logic [1:0]                   knob_pos;                  // gray position of the knob
    logic [31:0]                  lcg_state;
    voice_audio_pkg::sample_t     rnd;
    voice_ctrl_pkg::voice_mode_t  cur_mode;
    logic [3:0]                   cur_vol;

    voice_ctrl_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .pbs      (pbs),
        .vol      (vol),
        .in_beat  (in_beat),
        .mode     (mode),
        .volume   (volume),
        .out_beat (out_beat)
    );

    voice_checker u_checker (
        .clk        (clk),
        .rst        (rst),
        .mode       (mode),
        .volume     (volume),
        .out_beat   (out_beat),
        .ctrl_chk   (ctrl_chk),
        .exp_mode   (exp_mode),
        .exp_volume (exp_volume),
        .exp_beat   (exp_d2),
        .err_count  (err_count),
        .chk_count  (chk_count)
    );

    always #4 clk = ~clk;                                    // 8 ns period

    // two cycle delay line for expected beats
    always @(negedge clk) begin
        exp_d1 <= exp_now;
        exp_d2 <= exp_d1;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [1:0] gray_cw(input logic [1:0] k);
        case (k)
            2'b00:   return 2'b01;
            2'b01:   return 2'b11;
            2'b11:   return 2'b10;
            default: return 2'b00;
        endcase
    endfunction

    function automatic logic [1:0] gray_acw(input logic [1:0] k);
        case (k)
            2'b00:   return 2'b10;
            2'b10:   return 2'b11;
            2'b11:   return 2'b01;
            default: return 2'b00;
        endcase
    endfunction

    // gate, gain, clip, silence, all in plain integers
    function automatic voice_audio_pkg::sample_t predict_sample(
        input voice_audio_pkg::sample_t s, input voice_ctrl_pkg::voice_mode_t m,
        input logic [3:0] v);
        int x;
        int thr;
        int clip;
        thr  = int'(voice_audio_pkg::GATE_THRESHOLD);
        clip = int'(voice_audio_pkg::EFFECT_CLIP);
        x    = int'(s);
        if (m.noise_gate && x > -thr && x < thr) x = 0;
        x = x * int'(v);
        x = x >>> voice_audio_pkg::VOL_SHIFT;                // floor, not round
        if (m.effect && x > clip) x = clip;
        if (m.effect && x < -clip) x = -clip;
        if (m.mute || !m.talk) x = 0;
        return voice_audio_pkg::sample_t'(x);
    endfunction

    task automatic add_row(input logic [3:0] press, input int hold, input logic talk,
                           input int steps, input logic jump, input int sample,
                           input logic [3:0] mode_bits, input int vol_v, input int out_v);
        rows[n_rows].press      = press;
        rows[n_rows].hold       = 8'(hold);
        rows[n_rows].talk       = talk;
        rows[n_rows].steps      = 8'(steps);
        rows[n_rows].jump       = jump;
        rows[n_rows].sample     = voice_audio_pkg::sample_t'(sample);
        rows[n_rows].exp_mode   = voice_ctrl_pkg::voice_mode_t'(mode_bits);
        rows[n_rows].exp_vol    = 4'(vol_v);
        rows[n_rows].exp_sample = voice_audio_pkg::sample_t'(out_v);
        n_rows++;
    endtask

    task automatic build_table();
        // mode column is {talk, mute, effect, gate}, press bits are gate effect mute talk
        //      press    hold        talk  steps jump sample  mode     vol  out
        add_row(4'b0000, FULL_HOLD,  1'b0,   0,  1'b0,   1000, 4'b0000,  0,     0);
        add_row(4'b0010, SHORT_HOLD, 1'b0,   0,  1'b0,   -500, 4'b0000,  0,     0);
        add_row(4'b0000, FULL_HOLD,  1'b1,   4,  1'b0,   1000, 4'b1000,  4,   250);
        add_row(4'b0000, FULL_HOLD,  1'b1,  14,  1'b0,   1000, 4'b1000, 15,   937);
        add_row(4'b0000, FULL_HOLD,  1'b1,  -3,  1'b0,  -1000, 4'b1000, 12,  -750);
        add_row(4'b0000, FULL_HOLD,  1'b1,   0,  1'b1,  -1001, 4'b1000, 12,  -751);
        add_row(4'b0100, FULL_HOLD,  1'b1,   0,  1'b0,  32767, 4'b1010, 12,  4096);
        add_row(4'b1000, FULL_HOLD,  1'b1,   0,  1'b0,    200, 4'b1011, 12,     0);
        add_row(4'b0000, FULL_HOLD,  1'b1,   0,  1'b0,    256, 4'b1011, 12,   192);
        add_row(4'b0000, FULL_HOLD,  1'b1,   0,  1'b0, -32768, 4'b1011, 12, -4096);
        add_row(4'b0010, FULL_HOLD,  1'b1,   0,  1'b0,   1000, 4'b1111, 12,     0);
        add_row(4'b0110, FULL_HOLD,  1'b1,   0,  1'b0,   1000, 4'b1001, 12,   750);
        add_row(4'b0000, FULL_HOLD,  1'b0,   0,  1'b0,   1000, 4'b0001, 12,     0);
        add_row(4'b0000, FULL_HOLD,  1'b1, -13,  1'b0,   1000, 4'b1001,  0,     0);
        add_row(4'b1000, FULL_HOLD,  1'b1,   8,  1'b0,   -300, 4'b1000,  8,  -150);
        add_row(4'b0100, FULL_HOLD,  1'b1,   8,  1'b0,   3000, 4'b1010, 15,  2812);
    endtask

    task automatic press_buttons(input logic [3:0] mask, input int hold, input logic talk);
        @(negedge clk);
        pbs <= mask | {3'b000, talk};
        repeat (hold) @(negedge clk);
        pbs <= {3'b000, talk};                               // release, talk stays as set
        repeat (hold) @(negedge clk);
    endtask

    task automatic turn_knob(input int steps, input logic jump);
        int n;
        n = (steps < 0) ? -steps : steps;
        for (int i = 0; i < n; i++) begin
            @(negedge clk);
            knob_pos = (steps > 0) ? gray_cw(knob_pos) : gray_acw(knob_pos);
            vol <= knob_pos;
            repeat (3) @(negedge clk);                       // 4 cycles per step
        end
        if (jump) begin
            @(negedge clk);
            knob_pos = ~knob_pos;                            // both phases at once
            vol <= knob_pos;
            repeat (3) @(negedge clk);
        end
    endtask

    task automatic check_controls(input voice_ctrl_pkg::voice_mode_t m, input logic [3:0] v);
        @(negedge clk);
        exp_mode   <= m;
        exp_volume <= v;
        ctrl_chk   <= 1'b1;
        @(negedge clk);
        ctrl_chk   <= 1'b0;
    endtask

    task automatic send_sample(input voice_audio_pkg::sample_t s,
                               input voice_audio_pkg::sample_t e);
        @(negedge clk);
        in_beat.valid  <= 1'b1;
        in_beat.sample <= s;
        exp_now.valid  <= 1'b1;
        exp_now.sample <= e;
        @(negedge clk);
        in_beat.valid  <= 1'b0;
        exp_now.valid  <= 1'b0;
        repeat (3) @(negedge clk);                           // let the beat drain
    endtask

    task automatic apply_row(input row_t r);
        press_buttons(r.press, int'(r.hold), r.talk);
        turn_knob(int'(r.steps), r.jump);
        check_controls(r.exp_mode, r.exp_vol);
        send_sample(r.sample, r.exp_sample);
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("timeout: run did not finish within %0d ns", WATCHDOG_NS);
        $display("Checks failed");
        $finish;
    end

    initial begin
        clk        = 1'b0;
        rst        = 1'b1;
        pbs        = '0;
        vol        = '0;
        in_beat    = '0;
        exp_now    = '0;
        exp_d1     = '0;
        exp_d2     = '0;
        exp_mode   = '0;
        exp_volume = '0;
        ctrl_chk   = 1'b0;
        knob_pos   = 2'b00;
        lcg_state  = 32'hf6b0bbf3;
        n_rows     = 0;
        build_table();

        repeat (8) @(negedge clk);
        rst <= 1'b0;
        repeat (4) @(negedge clk);

        for (int i = 0; i < n_rows; i++) begin
            apply_row(rows[i]);
        end

        // random samples back to back with the last row's controls
        cur_mode = rows[NUM_ROWS-1].exp_mode;
        cur_vol  = rows[NUM_ROWS-1].exp_vol;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            @(negedge clk);
            lcg_state = lcg_next(lcg_state);
            rnd       = voice_audio_pkg::sample_t'(lcg_state[31:16]);
            in_beat.valid  <= 1'b1;
            in_beat.sample <= rnd;
            exp_now.valid  <= 1'b1;
            exp_now.sample <= predict_sample(rnd, cur_mode, cur_vol);
        end
        @(negedge clk);
        in_beat.valid <= 1'b0;
        exp_now.valid <= 1'b0;
        repeat (6) @(negedge clk);

        $display("checks run: %0d, errors: %0d", chk_count, err_count);
        if (err_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
voice_ctrl_pkg.sv
voice_audio_pkg.sv
input_sync.sv
mode_toggle.sv
volume_encoder.sv
audio_path.sv
voice_ctrl_top.sv
voice_checker.sv
tb_voice_ctrl.sv

/* Bender.yml */
package:
  name: voice_ctrl

sources:
  - voice_ctrl_pkg.sv
  - voice_audio_pkg.sv
  - input_sync.sv
  - mode_toggle.sv
  - volume_encoder.sv
  - audio_path.sv
  - voice_ctrl_top.sv
  - target: test
    files:
      - voice_checker.sv
      - tb_voice_ctrl.sv
